// ==== rtl/procPkg.sv ====
// Processor ISA and datapath types
package procPkg;

   localparam int DataWidth = 16;            // One machine word
   localparam int RegCount = 8;
   localparam int RegAddrBits = 3;
   localparam int ImemAddrBits = 8;          // 256 instruction words
   localparam int DmemAddrBits = 8;          // 256 data words
   localparam logic [RegAddrBits-1:0] LinkReg = 3'd7;  // JAL destination

   // Major opcodes, bits 15:11
   typedef enum logic [4:0] {
      OpHalt  = 5'b00000,
      OpNop   = 5'b00001,
      OpJ     = 5'b00100,
      OpJal   = 5'b00110,
      OpAddi  = 5'b01000,
      OpSubi  = 5'b01001,
      OpXori  = 5'b01010,
      OpAndni = 5'b01011,
      OpBeqz  = 5'b01100,
      OpBnez  = 5'b01101,
      OpBltz  = 5'b01110,
      OpSt    = 5'b10000,
      OpLd    = 5'b10001,
      OpSlbi  = 5'b10010,
      OpLbi   = 5'b11000,
      OpAluR  = 5'b11011
   } opcode_e;

   // R-format funct, bits 1:0
   typedef enum logic [1:0] {FnAdd = 2'b00, FnSub = 2'b01, FnXor = 2'b10, FnAndn = 2'b11} funct_e;

   typedef enum logic [2:0] {AluAdd, AluSub, AluXor, AluAndn, AluSlbi} aluOp_e;
   typedef enum logic [2:0] {ImmSext5, ImmZext5, ImmSext8, ImmZext8, ImmSext11} immSel_e;
   typedef enum logic [1:0] {DestRd, DestRt, DestRs, DestLink} destSel_e;
   typedef enum logic [1:0] {WbAlu, WbMem, WbLink, WbImm} wbSel_e;
   typedef enum logic [2:0] {BrNone, BrEqz, BrNez, BrLtz, BrAlways} brCond_e;

   typedef struct packed {
      logic     regWrite;
      destSel_e destSel;
      immSel_e  immSel;
      aluOp_e   aluOp;
      logic     aluSrcImm;   // Second ALU operand is the immediate
      logic     memWrite;
      wbSel_e   wbSel;
      brCond_e  brCond;
      logic     halt;
      logic     illegal;
   } ctrl_t;

   typedef struct packed {
      logic [DataWidth-1:0]   rsVal;
      logic [DataWidth-1:0]   rtVal;
      logic [DataWidth-1:0]   imm;
      logic [RegAddrBits-1:0] destAddr;
   } operands_t;

   typedef struct packed {
      logic                   en;
      logic [RegAddrBits-1:0] addr;
      logic [DataWidth-1:0]   data;
   } regWrite_t;

   typedef struct packed {
      logic                    valid;
      logic [DataWidth-1:0]    pc;
      logic                    regWe;
      logic [RegAddrBits-1:0]  regAddr;
      logic [DataWidth-1:0]    regData;
      logic                    memWe;
      logic [DmemAddrBits-1:0] memAddr;
      logic [DataWidth-1:0]    memData;   // Store data or load result
   } retire_t;

   typedef struct packed {
      logic [ImemAddrBits-1:0] addr;
      logic [DataWidth-1:0]    instr;
   } progLoad_t;

endpackage

// ==== rtl/fetch.sv ====
// Instruction fetch and run control
`timescale 1ns/1ps
module fetch (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic                            loadValid,
   output logic                            loadReady,
   input  procPkg::progLoad_t              load,
   input  logic                            runValid,
   output logic                            runReady,
   input  procPkg::ctrl_t                  ctrl,
   input  logic                            taken,
   input  logic [procPkg::DataWidth-1:0]   target,
   output logic [procPkg::DataWidth-1:0]   instr,
   output logic [procPkg::DataWidth-1:0]   pc,
   output logic [procPkg::DataWidth-1:0]   pcNext1,
   output logic                            busy,
   output logic                            err
);

   typedef enum logic [1:0] {Idle, Running, Faulted} runState_e;

   runState_e state;
   logic [procPkg::DataWidth-1:0] imem [1 << procPkg::ImemAddrBits];

   // Program load port, Idle only
   always_ff @(posedge clk) begin
      if (loadValid && loadReady) begin
         imem[load.addr] <= load.instr;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= Idle;
         pc    <= '0;
      end else begin
         case (state)
            Idle: begin
               if (runValid && runReady) begin
                  state <= Running;
                  pc    <= '0;   // Every run starts at word 0
               end
            end
            Running: begin
               if (ctrl.illegal) begin
                  state <= Faulted;   // Sticky until reset
               end else if (ctrl.halt) begin
                  state <= Idle;
               end else begin
                  pc <= taken ? target : pcNext1;
               end
            end
            default: state <= Faulted;
         endcase
      end
   end

   assign busy      = (state == Running);
   assign err       = (state == Faulted);
   assign loadReady = (state == Idle);
   assign runReady  = (state == Idle);
   assign pcNext1   = pc + 1'b1;

   // Outside a run the core sees NOPs, so nothing gets written
   assign instr = busy ? imem[pc[procPkg::ImemAddrBits-1:0]] : {procPkg::OpNop, 11'd0};

endmodule

// ==== rtl/control.sv ====
// Main instruction decoder
`timescale 1ns/1ps
module control (
   input  logic [procPkg::DataWidth-1:0] instr,
   output procPkg::ctrl_t                ctrl
);

   procPkg::opcode_e opcode;
   procPkg::funct_e  funct;

   assign opcode = procPkg::opcode_e'(instr[15:11]);
   assign funct  = procPkg::funct_e'(instr[1:0]);

   always_comb begin
      ctrl = '0;   // No writes, no branch
      case (opcode)
         procPkg::OpHalt: ctrl.halt = 1'b1;
         procPkg::OpNop: ;
         procPkg::OpJ: begin
            ctrl.immSel = procPkg::ImmSext11;
            ctrl.brCond = procPkg::BrAlways;
         end
         procPkg::OpJal: begin
            ctrl.immSel   = procPkg::ImmSext11;
            ctrl.brCond   = procPkg::BrAlways;
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = procPkg::DestLink;   // r7 gets PC+1
            ctrl.wbSel    = procPkg::WbLink;
         end
         procPkg::OpAddi, procPkg::OpSubi, procPkg::OpXori, procPkg::OpAndni: begin
            ctrl.regWrite  = 1'b1;
            ctrl.destSel   = procPkg::DestRt;
            ctrl.aluSrcImm = 1'b1;
            ctrl.wbSel     = procPkg::WbAlu;
            // Arithmetic sign extends, logic zero extends
            ctrl.immSel    = opcode[1] ? procPkg::ImmZext5 : procPkg::ImmSext5;
            case (opcode)
               procPkg::OpSubi: ctrl.aluOp = procPkg::AluSub;
               procPkg::OpXori: ctrl.aluOp = procPkg::AluXor;
               procPkg::OpAndni: ctrl.aluOp = procPkg::AluAndn;
               default: ctrl.aluOp = procPkg::AluAdd;
            endcase
         end
         procPkg::OpBeqz: begin
            ctrl.immSel = procPkg::ImmSext8;
            ctrl.brCond = procPkg::BrEqz;
         end
         procPkg::OpBnez: begin
            ctrl.immSel = procPkg::ImmSext8;
            ctrl.brCond = procPkg::BrNez;
         end
         procPkg::OpBltz: begin
            ctrl.immSel = procPkg::ImmSext8;
            ctrl.brCond = procPkg::BrLtz;
         end
         procPkg::OpSt, procPkg::OpLd: begin
            ctrl.immSel    = procPkg::ImmSext5;   // Address is Rs + imm5
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = procPkg::AluAdd;
            ctrl.memWrite  = (opcode == procPkg::OpSt);
            ctrl.regWrite  = (opcode == procPkg::OpLd);
            ctrl.destSel   = procPkg::DestRt;
            ctrl.wbSel     = procPkg::WbMem;
         end
         procPkg::OpSlbi: begin
            ctrl.regWrite  = 1'b1;
            ctrl.destSel   = procPkg::DestRs;
            ctrl.immSel    = procPkg::ImmZext8;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = procPkg::AluSlbi;
            ctrl.wbSel     = procPkg::WbAlu;
         end
         procPkg::OpLbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = procPkg::DestRs;
            ctrl.immSel   = procPkg::ImmSext8;
            ctrl.wbSel    = procPkg::WbImm;   // Immediate straight to Rs
         end
         procPkg::OpAluR: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = procPkg::DestRd;
            ctrl.wbSel    = procPkg::WbAlu;
            case (funct)
               procPkg::FnSub: ctrl.aluOp = procPkg::AluSub;
               procPkg::FnXor: ctrl.aluOp = procPkg::AluXor;
               procPkg::FnAndn: ctrl.aluOp = procPkg::AluAndn;
               default: ctrl.aluOp = procPkg::AluAdd;
            endcase
         end
         default: ctrl.illegal = 1'b1;   // Writes stay low from the default
      endcase
   end

endmodule

// ==== rtl/decode.sv ====
// Register file and operand decode
`timescale 1ns/1ps
module decode (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic [procPkg::DataWidth-1:0] instr,
   input  procPkg::ctrl_t                ctrl,
   input  procPkg::regWrite_t            wr,
   output procPkg::operands_t            ops
);

   logic [procPkg::DataWidth-1:0] regs [procPkg::RegCount];

   // One write port, driven by writeback
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < procPkg::RegCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.en) begin
         regs[wr.addr] <= wr.data;
      end
   end

   always_comb begin
      // Two read ports, old value seen within the writing cycle
      ops.rsVal = regs[instr[10:8]];
      ops.rtVal = regs[instr[7:5]];   // Also the store data

      case (ctrl.immSel)
         procPkg::ImmSext5: ops.imm = {{(procPkg::DataWidth-5){instr[4]}}, instr[4:0]};
         procPkg::ImmZext5: ops.imm = {{(procPkg::DataWidth-5){1'b0}}, instr[4:0]};
         procPkg::ImmSext8: ops.imm = {{(procPkg::DataWidth-8){instr[7]}}, instr[7:0]};
         procPkg::ImmZext8: ops.imm = {{(procPkg::DataWidth-8){1'b0}}, instr[7:0]};
         default: ops.imm = {{(procPkg::DataWidth-11){instr[10]}}, instr[10:0]};  // disp11
      endcase

      case (ctrl.destSel)
         procPkg::DestRd: ops.destAddr = instr[4:2];
         procPkg::DestRt: ops.destAddr = instr[7:5];
         procPkg::DestRs: ops.destAddr = instr[10:8];
         default: ops.destAddr = procPkg::LinkReg;
      endcase
   end

endmodule

// ==== rtl/execute.sv ====
// ALU and branch resolution
`timescale 1ns/1ps
module execute (
   input  procPkg::ctrl_t                ctrl,
   input  procPkg::operands_t            ops,
   input  logic [procPkg::DataWidth-1:0] pcNext1,
   output logic [procPkg::DataWidth-1:0] aluResult,
   output logic                          taken,
   output logic [procPkg::DataWidth-1:0] target
);

   logic [procPkg::DataWidth-1:0] opB;

   assign opB = ctrl.aluSrcImm ? ops.imm : ops.rtVal;

   always_comb begin
      case (ctrl.aluOp)
         procPkg::AluAdd: aluResult = ops.rsVal + opB;   // Also load/store address
         procPkg::AluSub: aluResult = ops.rsVal - opB;
         procPkg::AluXor: aluResult = ops.rsVal ^ opB;
         procPkg::AluAndn: aluResult = ops.rsVal & ~opB;
         procPkg::AluSlbi: aluResult = {ops.rsVal[7:0], 8'h00} | opB;
         default: aluResult = ops.rsVal + opB;
      endcase
   end

   // Condition always tests Rs
   always_comb begin
      case (ctrl.brCond)
         procPkg::BrEqz: taken = (ops.rsVal == '0);
         procPkg::BrNez: taken = (ops.rsVal != '0);
         procPkg::BrLtz: taken = ops.rsVal[procPkg::DataWidth-1];
         procPkg::BrAlways: taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   // imm8 for branches, disp11 for jumps, both relative to PC+1
   assign target = pcNext1 + ops.imm;

endmodule

// ==== rtl/memory.sv ====
// Data memory
`timescale 1ns/1ps
module memory (
   input  logic                          clk,
   input  logic                          rstN,
   input  procPkg::ctrl_t                ctrl,
   input  logic [procPkg::DataWidth-1:0] addr,
   input  logic [procPkg::DataWidth-1:0] wrData,
   output logic [procPkg::DataWidth-1:0] memData
);

   logic [procPkg::DataWidth-1:0] mem [1 << procPkg::DmemAddrBits];
   logic [procPkg::DmemAddrBits-1:0] idx;

   assign idx = addr[procPkg::DmemAddrBits-1:0];   // Word address wraps

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < (1 << procPkg::DmemAddrBits); i++) begin
            mem[i] <= '0;
         end
      end else if (ctrl.memWrite) begin
         mem[idx] <= wrData;
      end
   end

   assign memData = mem[idx];   // Async read

endmodule

// ==== rtl/writeback.sv ====
// Writeback select and retire record
`timescale 1ns/1ps
module writeback (
   input  procPkg::ctrl_t                ctrl,
   input  procPkg::operands_t            ops,
   input  logic [procPkg::DataWidth-1:0] aluResult,
   input  logic [procPkg::DataWidth-1:0] memData,
   input  logic [procPkg::DataWidth-1:0] pc,
   input  logic [procPkg::DataWidth-1:0] pcNext1,
   input  logic                          busy,
   output procPkg::regWrite_t            wr,
   output procPkg::retire_t              retire
);

   logic                          retiring;
   logic [procPkg::DataWidth-1:0] wbData;

   assign retiring = busy && !ctrl.illegal;   // Illegal never retires

   always_comb begin
      case (ctrl.wbSel)
         procPkg::WbAlu: wbData = aluResult;
         procPkg::WbMem: wbData = memData;
         procPkg::WbLink: wbData = pcNext1;
         default: wbData = ops.imm;   // LBI
      endcase
   end

   assign wr.en   = retiring && ctrl.regWrite;
   assign wr.addr = ops.destAddr;
   assign wr.data = wbData;

   always_comb begin
      retire.valid   = retiring;
      retire.pc      = pc;
      retire.regWe   = wr.en;
      retire.regAddr = ops.destAddr;
      retire.regData = wbData;
      retire.memWe   = retiring && ctrl.memWrite;
      retire.memAddr = aluResult[procPkg::DmemAddrBits-1:0];
      retire.memData = ctrl.memWrite ? ops.rtVal : memData;   // Store data on ST
   end

endmodule

// ==== rtl/proc.sv ====
// Single-cycle processor top
`timescale 1ns/1ps
module proc (
   input  logic               clk,
   input  logic               rstN,
   input  logic               loadValid,
   output logic               loadReady,
   input  procPkg::progLoad_t load,
   input  logic               runValid,
   output logic               runReady,
   output logic               busy,
   output logic               err,
   output procPkg::retire_t   retire
);

   logic [procPkg::DataWidth-1:0] instr;
   logic [procPkg::DataWidth-1:0] pc;
   logic [procPkg::DataWidth-1:0] pcNext1;
   logic [procPkg::DataWidth-1:0] aluResult;
   logic [procPkg::DataWidth-1:0] memData;
   logic [procPkg::DataWidth-1:0] target;
   logic                          taken;   // Redirect back to fetch
   procPkg::ctrl_t                ctrl;
   procPkg::operands_t            ops;
   procPkg::regWrite_t            wr;

   fetch fetch_i (
      .clk(clk), .rstN(rstN),
      .loadValid(loadValid), .loadReady(loadReady), .load(load),
      .runValid(runValid), .runReady(runReady),
      .ctrl(ctrl), .taken(taken), .target(target),
      .instr(instr), .pc(pc), .pcNext1(pcNext1),
      .busy(busy), .err(err)
   );

   control control_i (.instr(instr), .ctrl(ctrl));

   decode decode_i (
      .clk(clk), .rstN(rstN), .instr(instr), .ctrl(ctrl), .wr(wr), .ops(ops)
   );

   execute execute_i (
      .ctrl(ctrl), .ops(ops), .pcNext1(pcNext1),
      .aluResult(aluResult), .taken(taken), .target(target)
   );

   memory memory_i (
      .clk(clk), .rstN(rstN), .ctrl(ctrl),
      .addr(aluResult), .wrData(ops.rtVal), .memData(memData)
   );

   writeback writeback_i (
      .ctrl(ctrl), .ops(ops), .aluResult(aluResult), .memData(memData),
      .pc(pc), .pcNext1(pcNext1), .busy(busy),
      .wr(wr), .retire(retire)
   );

endmodule

// ==== bench/proc_properties.sv ====
// Top-level handshake assertions
`timescale 1ns/1ps
module proc_properties (
   input logic             clk,
   input logic             rstN,
   input logic             loadReady,
   input logic             busy,
   input logic             err,
   input procPkg::retire_t retire
);

   // Records only come out of a running core
   retireWhileBusy: assert property (@(posedge clk) disable iff (!rstN) retire.valid |-> busy)
      else $error("retire.valid high while the core is not busy");

   loadOnlyIdle: assert property (@(posedge clk) disable iff (!rstN)
      !(loadReady && (busy || err)))
      else $error("loadReady high while the core is busy or faulted");

   // Faulted is sticky
   noRunAfterErr: assert property (@(posedge clk) disable iff (!rstN) err |=> !busy)
      else $error("busy rose after err");

endmodule

bind proc proc_properties properties_i (
   .clk(clk), .rstN(rstN), .loadReady(loadReady), .busy(busy), .err(err), .retire(retire)
);

// ==== bench/procTb.sv ====
// Processor random-program testbench
`timescale 1ns/1ps
module procTb;

   localparam int NumPrograms = 20;   // Last one ends in an undefined opcode
   localparam int CycleLimit = NumPrograms * (64 + 64 + 10) + 200;
   localparam logic [4:0] LegalOps [15] = '{procPkg::OpNop, procPkg::OpJ, procPkg::OpJal,
      procPkg::OpAddi, procPkg::OpSubi, procPkg::OpXori, procPkg::OpAndni, procPkg::OpBeqz,
      procPkg::OpBnez, procPkg::OpBltz, procPkg::OpSt, procPkg::OpLd, procPkg::OpSlbi,
      procPkg::OpLbi, procPkg::OpAluR};
   localparam logic [4:0] UndefOps [4] = '{5'b00010, 5'b01111, 5'b10101, 5'b11111};

   logic clk = 1'b0;
   logic rstN;
   logic loadValid;
   logic loadReady;
   logic runValid;
   logic runReady;
   logic busy;
   logic err;
   procPkg::progLoad_t load;
   procPkg::retire_t retire;

   logic [15:0] prog [64];    // Current program with HALT or bad opcode last
   logic [15:0] mRegs [8];    // ISA model state kept across programs
   logic [15:0] mMem [256];
   int progLen;
   int errors = 0;
   int checks = 0;
   int cycles = 0;

   proc dut_i (
      .clk(clk), .rstN(rstN), .loadValid(loadValid), .loadReady(loadReady), .load(load),
      .runValid(runValid), .runReady(runReady), .busy(busy), .err(err), .retire(retire)
   );

   always #4 clk = ~clk;   // 8 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CycleLimit) begin
         $display("Timeout after %0d cycles, the run never finished", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic compareWord(input string what, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Core stopped in Idle or Faulted
   task automatic checkStatus(input logic expErr);
      compareWord("busy", 16'(busy), 16'd0);
      compareWord("err", 16'(err), 16'(expErr));
      compareWord("loadReady", 16'(loadReady), 16'(!expErr));
      compareWord("runReady", 16'(runReady), 16'(!expErr));
   endtask

   task automatic makeProgram(input bit endIllegal);
      logic [4:0] op;
      int room;
      progLen = $urandom_range(63, 1) + 1;
      for (int i = 0; i < progLen - 1; i++) begin
         op = LegalOps[$urandom_range(14)];
         room = progLen - 2 - i;   // Largest forward step that still lands on the last word
         prog[i] = {op, 11'($urandom)};
         if (op inside {procPkg::OpBeqz, procPkg::OpBnez, procPkg::OpBltz})
            prog[i][7:0] = 8'($urandom_range(room));
         else if (op inside {procPkg::OpJ, procPkg::OpJal})
            prog[i][10:0] = 11'($urandom_range(room));
      end
      prog[progLen-1] = endIllegal ? {UndefOps[$urandom_range(3)], 11'd0} : 16'h0000;
   endtask

   task automatic loadProgram();
      for (int i = 0; i < progLen; i++) begin
         @(posedge clk);   // Also the transfer edge of the previous word
         loadValid <= 1'b1;
         load.addr <= 8'(i);
         load.instr <= prog[i];
         @(negedge clk);
         while (!loadReady) @(negedge clk);
      end
      @(posedge clk);
      loadValid <= 1'b0;
   endtask

   task automatic runProgram(input bit endIllegal);
      logic [15:0] pc;
      logic [15:0] nextPc;
      logic [15:0] ins;
      logic [15:0] rs;
      logic [15:0] rt;
      logic [15:0] s5;
      logic [15:0] z5;
      logic [7:0] ea;
      logic [4:0] op;
      procPkg::retire_t exp;
      bit memChk;
      bit done;
      @(posedge clk);
      runValid <= 1'b1;
      @(negedge clk);
      while (!runReady) @(negedge clk);
      @(posedge clk);   // Run accepted here
      runValid <= 1'b0;
      pc = '0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);   // One instruction per cycle
         ins = prog[pc[5:0]];
         compareWord("busy", 16'(busy), 16'd1);
         if (endIllegal && pc == 16'(progLen - 1)) begin
            compareWord("retire.valid on bad opcode", 16'(retire.valid), 16'd0);
            @(negedge clk);
            checkStatus(1'b1);   // Faulted until reset
            @(posedge clk);
            runValid <= 1'b1;   // A run request must not restart a faulted core
            repeat (3) begin
               @(negedge clk);
               checkStatus(1'b1);
               compareWord("retire.valid while faulted", 16'(retire.valid), 16'd0);
            end
            @(posedge clk);
            runValid <= 1'b0;
            done = 1'b1;
         end else begin
            op = ins[15:11];
            rs = mRegs[ins[10:8]];
            rt = mRegs[ins[7:5]];
            s5 = {{11{ins[4]}}, ins[4:0]};
            z5 = {11'd0, ins[4:0]};
            ea = 8'(rs + s5);   // Word address wraps at 256
            exp = '0;
            exp.valid = 1'b1;
            exp.pc = pc;
            exp.regWe = 1'b1;
            exp.regAddr = ins[7:5];
            case (op)
               procPkg::OpAddi: exp.regData = rs + s5;
               procPkg::OpSubi: exp.regData = rs - s5;
               procPkg::OpXori: exp.regData = rs ^ z5;
               procPkg::OpAndni: exp.regData = rs & ~z5;
               procPkg::OpLd: exp.regData = mMem[ea];
               procPkg::OpLbi: exp.regData = {{8{ins[7]}}, ins[7:0]};
               procPkg::OpSlbi: exp.regData = (rs << 8) | {8'h00, ins[7:0]};
               procPkg::OpJal: exp.regData = pc + 16'd1;
               procPkg::OpAluR: exp.regData = (ins[1:0] == 2'd0) ? rs + rt
                  : (ins[1:0] == 2'd1) ? rs - rt : (ins[1:0] == 2'd2) ? rs ^ rt : rs & ~rt;
               default: exp.regWe = 1'b0;   // NOP, HALT, ST, branches, J
            endcase
            if (op inside {procPkg::OpLbi, procPkg::OpSlbi}) exp.regAddr = ins[10:8];
            if (op == procPkg::OpAluR) exp.regAddr = ins[4:2];
            if (op == procPkg::OpJal) exp.regAddr = 3'd7;   // Link register
            exp.memWe = (op == procPkg::OpSt);
            exp.memAddr = ea;
            exp.memData = exp.memWe ? rt : mMem[ea];
            memChk = op inside {procPkg::OpSt, procPkg::OpLd};
            nextPc = pc + 16'd1;
            if ((op == procPkg::OpBeqz && rs == 16'd0) || (op == procPkg::OpBnez && rs != 16'd0)
                  || (op == procPkg::OpBltz && rs[15]))
               nextPc = pc + 16'd1 + {{8{ins[7]}}, ins[7:0]};
            if (op inside {procPkg::OpJ, procPkg::OpJal})
               nextPc = pc + 16'd1 + {{5{ins[10]}}, ins[10:0]};

            compareWord("retire.valid", 16'(retire.valid), 16'(exp.valid));
            compareWord("retire.pc", retire.pc, exp.pc);
            compareWord("retire.regWe", 16'(retire.regWe), 16'(exp.regWe));
            compareWord("retire.memWe", 16'(retire.memWe), 16'(exp.memWe));
            if (exp.regWe) begin
               compareWord("retire.regAddr", 16'(retire.regAddr), 16'(exp.regAddr));
               compareWord("retire.regData", retire.regData, exp.regData);
            end
            if (memChk) begin
               compareWord("retire.memAddr", 16'(retire.memAddr), 16'(exp.memAddr));
               compareWord("retire.memData", retire.memData, exp.memData);
            end

            if (exp.regWe) mRegs[exp.regAddr] = exp.regData;
            if (exp.memWe) mMem[ea] = rt;
            pc = nextPc;
            if (op == procPkg::OpHalt) begin
               @(negedge clk);
               checkStatus(1'b0);   // Back to Idle one cycle after HALT
               done = 1'b1;
            end
         end
      end
   endtask

   initial begin
      void'($urandom(43542));
      rstN = 1'b0;
      loadValid = 1'b0;
      load = '0;
      runValid = 1'b0;
      for (int r = 0; r < 8; r++) mRegs[r] = '0;
      for (int a = 0; a < 256; a++) mMem[a] = '0;
      repeat (3) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      compareWord("retire.valid after reset", 16'(retire.valid), 16'd0);
      checkStatus(1'b0);
      for (int p = 0; p < NumPrograms; p++) begin
         makeProgram(p == NumPrograms - 1);
         loadProgram();
         runProgram(p == NumPrograms - 1);
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== wiscProc.f ====
rtl/procPkg.sv
rtl/fetch.sv
rtl/control.sv
rtl/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/writeback.sv
rtl/proc.sv
bench/proc_properties.sv
bench/procTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= procTb
FILELIST  ?= wiscProc.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '** FAIL **' $(LOG); then \
		echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
